//--- list.f
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_addr_select.sv
verilog/itlb.sv
verilog/icache_bank.sv
verilog/fill_ctrl.sv
verilog/fetch_top.sv
sim/fetch_chk.sv
sim/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim +verilator+error+limit+1000 2>&1 | tee sim.log

grep -q "^Simulation passed$" sim.log 2>/dev/null \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

//--- sim/fetch_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_tb;

    localparam int TEST_CYCLES = 400;   // rough length of all tests together
    localparam int WAIT_LIMIT  = 100;   // longest wait for lines or a request

    logic                                           clk;
    logic                                           reset_i;
    logic [31:0]                                    init_addr_i;
    logic                                           init_i;
    logic [`FETCH_LINE_W-1:0]                       bp_fip_even_i;
    logic [`FETCH_LINE_W-1:0]                       bp_fip_odd_i;
    logic                                           branch_i;
    logic [`FETCH_LINE_W-1:0]                       wb_fip_even_i;
    logic [`FETCH_LINE_W-1:0]                       wb_fip_odd_i;
    logic                                           resteer_i;
    logic                                           ld_even_i;
    logic                                           ld_odd_i;
    fetch_pkg::tlb_entry_t [`FETCH_TLB_ENTRIES-1:0] tlb_entries_i;
    logic                                           mem_fill_i;
    logic [`FETCH_DATA_W-1:0]                       mem_fill_data_i;
    logic [`FETCH_LINE_W-1:0]                       fip_even_o;
    logic [`FETCH_LINE_W-1:0]                       fip_odd_o;
    fetch_pkg::fetch_line_t                         line_even_o;
    fetch_pkg::fetch_line_t                         line_odd_o;
    logic                                           mem_req_valid_o;
    fetch_pkg::mem_req_t                            mem_req_o;

    logic [31:0]              rng_state;
    int                       err_count;
    int                       test_count;
    int                       test_fail_count;
    logic [`FETCH_LINE_W-1:0] seq_even;   // expected sequential registers
    logic [`FETCH_LINE_W-1:0] seq_odd;

    fetch_top u_fetch_top (
        .clk             (clk),
        .reset_i         (reset_i),
        .init_addr_i     (init_addr_i),
        .init_i          (init_i),
        .bp_fip_even_i   (bp_fip_even_i),
        .bp_fip_odd_i    (bp_fip_odd_i),
        .branch_i        (branch_i),
        .wb_fip_even_i   (wb_fip_even_i),
        .wb_fip_odd_i    (wb_fip_odd_i),
        .resteer_i       (resteer_i),
        .ld_even_i       (ld_even_i),
        .ld_odd_i        (ld_odd_i),
        .tlb_entries_i   (tlb_entries_i),
        .mem_fill_i      (mem_fill_i),
        .mem_fill_data_i (mem_fill_data_i),
        .fip_even_o      (fip_even_o),
        .fip_odd_o       (fip_odd_o),
        .line_even_o     (line_even_o),
        .line_odd_o      (line_odd_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // with an identity map the frame bits are the low page bits of the line
    function automatic logic [`FETCH_PLINE_W-1:0] phys_line(input logic [`FETCH_LINE_W-1:0] line);
        return {line[10:8], line[7:0]};
    endfunction

    function automatic logic [`FETCH_DATA_W-1:0] line_data(input logic [`FETCH_PLINE_W-1:0] pline);
        return {8{{5'b0, pline}}};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_hex(input string name, input logic [`FETCH_DATA_W-1:0] got,
                              input logic [`FETCH_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %0h expected %0h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
            test_fail_count++;
        end
    endtask

    task automatic setup_tlb();
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            tlb_entries_i[i] = '0;
        end
        // pages 1 to 5 mapped, page 6 is MMIO, pages 0 and 7 unmapped
        for (int p = 1; p <= 6; p++) begin
            tlb_entries_i[p-1] = '{vpn: 20'(p), pfn: 20'(p), valid: 1'b1,
                                   present: 1'b1, rw: 1'b0, pcd: (p == 6)};
        end
    endtask

    task automatic wait_lines(input logic [`FETCH_LINE_W-1:0] exp_even,
                              input logic [`FETCH_LINE_W-1:0] exp_odd);
        int n;
        n = 0;
        @(negedge clk);
        while (!(line_even_o.valid && line_odd_o.valid) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_failure("fetch lines never became valid");
        end else begin
            expect_hex("line_even_o.data", line_even_o.data, line_data(phys_line(exp_even)));
            expect_hex("line_odd_o.data", line_odd_o.data, line_data(phys_line(exp_odd)));
        end
    endtask

    // fips as given, first lookup misses, then both lines fill
    task automatic expect_refill(input logic [`FETCH_LINE_W-1:0] exp_even,
                                 input logic [`FETCH_LINE_W-1:0] exp_odd);
        @(negedge clk);
        expect_hex("fip_even_o", fip_even_o, exp_even);
        expect_hex("fip_odd_o", fip_odd_o, exp_odd);
        @(negedge clk);
        expect_hex("line_even_o.miss", line_even_o.miss, 1'b1);
        expect_hex("line_odd_o.miss", line_odd_o.miss, 1'b1);
        wait_lines(exp_even, exp_odd);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_init();
        int errs;
        errs = err_count;
        next_cycle();
        init_addr_i = 32'h0000_1000;   // bit 4 clear
        init_i      = 1'b1;
        expect_refill(28'h101, 28'h102);
        next_cycle();
        init_i = 1'b0;
        next_cycle();
        init_addr_i = 32'h0000_1030;   // bit 4 set, pair swaps
        init_i      = 1'b1;
        expect_refill(28'h105, 28'h104);
        next_cycle();
        init_i = 1'b0;
        finish_test("init", errs);
    endtask

    task automatic test_priority();
        int                       errs;
        logic [2:0]               combo;
        logic [`FETCH_LINE_W-1:0] exp_even;
        logic [`FETCH_LINE_W-1:0] exp_odd;
        errs = err_count;
        for (int c = 0; c < 8; c++) begin
            next_cycle();
            combo         = 3'(c);
            init_addr_i   = 32'h0000_7000;   // page 7 is unmapped so nothing is filled
            wb_fip_even_i = 28'h7a0;
            wb_fip_odd_i  = 28'h7a1;
            bp_fip_even_i = 28'h7c0;
            bp_fip_odd_i  = 28'h7c1;
            init_i        = combo[2];
            resteer_i     = combo[1];
            branch_i      = combo[0];
            @(negedge clk);
            if (combo[2]) begin
                exp_even = 28'h701;
                exp_odd  = 28'h702;
            end else if (combo[1]) begin
                exp_even = 28'h7a0;
                exp_odd  = 28'h7a1;
            end else if (combo[0]) begin
                exp_even = 28'h7c0;
                exp_odd  = 28'h7c1;
            end else begin
                exp_even = seq_even;
                exp_odd  = seq_odd;
            end
            expect_hex("fip_even_o", fip_even_o, exp_even);
            expect_hex("fip_odd_o", fip_odd_o, exp_odd);
            expect_hex("mem_req_valid_o", mem_req_valid_o, 1'b0);
        end
        next_cycle();
        init_i    = 1'b0;
        resteer_i = 1'b0;
        branch_i  = 1'b0;
        finish_test("priority", errs);
    endtask

    task automatic test_sequential();
        int errs;
        errs = err_count;
        next_cycle();
        bp_fip_even_i = 28'h300;
        bp_fip_odd_i  = 28'h301;
        branch_i      = 1'b1;
        ld_even_i     = 1'b1;
        ld_odd_i      = 1'b1;
        seq_even      = 28'h302;   // branch target plus two lines
        seq_odd       = 28'h303;
        next_cycle();
        branch_i  = 1'b0;
        ld_even_i = 1'b0;
        ld_odd_i  = 1'b0;
        @(negedge clk);
        expect_hex("fip_even_o", fip_even_o, seq_even);
        expect_hex("fip_odd_o", fip_odd_o, seq_odd);
        next_cycle();
        ld_even_i = 1'b1;
        seq_even  = seq_even + 28'd2;
        next_cycle();
        ld_even_i = 1'b0;
        @(negedge clk);
        expect_hex("fip_even_o", fip_even_o, seq_even);
        expect_hex("fip_odd_o", fip_odd_o, seq_odd);
        next_cycle();
        ld_odd_i = 1'b1;
        seq_odd  = seq_odd + 28'd2;
        next_cycle();
        ld_odd_i = 1'b0;
        @(negedge clk);
        expect_hex("fip_even_o", fip_even_o, seq_even);
        expect_hex("fip_odd_o", fip_odd_o, seq_odd);
        wait_lines(seq_even, seq_odd);
        repeat (4) begin           // same address again hits with no request
            @(negedge clk);
            expect_hex("line_even_o.valid", line_even_o.valid, 1'b1);
            expect_hex("line_odd_o.valid", line_odd_o.valid, 1'b1);
            expect_hex("mem_req_valid_o", mem_req_valid_o, 1'b0);
        end
        finish_test("sequential", errs);
    endtask

    task automatic check_blocked_page(input logic [`FETCH_LINE_W-1:0] line, input logic [3:0] flags);
        next_cycle();
        bp_fip_even_i = line;
        bp_fip_odd_i  = line + 28'd1;
        branch_i      = 1'b1;
        @(negedge clk);
        repeat (3) begin
            @(negedge clk);
            expect_hex("line_even_o flags", {line_even_o.valid, line_even_o.miss,
                       line_even_o.tlb_miss, line_even_o.prot}, flags);
            expect_hex("line_odd_o flags", {line_odd_o.valid, line_odd_o.miss,
                       line_odd_o.tlb_miss, line_odd_o.prot}, flags);
            expect_hex("mem_req_valid_o", mem_req_valid_o, 1'b0);
        end
        next_cycle();
        branch_i = 1'b0;
    endtask

    task automatic test_tlb();
        int errs;
        errs = err_count;
        check_blocked_page(28'h710, 4'b0010);   // valid, miss, tlb_miss, prot
        check_blocked_page(28'h610, 4'b0001);
        finish_test("tlb", errs);
    endtask

    task automatic test_dual_miss();
        int   errs;
        int   n;
        logic even_filled;
        logic seen_odd;
        errs        = err_count;
        n           = 0;
        even_filled = 1'b0;
        seen_odd    = 1'b0;
        next_cycle();
        wb_fip_even_i = 28'h520;
        wb_fip_odd_i  = 28'h521;
        resteer_i     = 1'b1;
        while (!seen_odd && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (mem_req_valid_o && !mem_req_o.bank) begin
                expect_hex("mem_req_o.addr", mem_req_o.addr, phys_line(28'h520));
                if (mem_fill_i) begin
                    even_filled = 1'b1;
                end
            end else if (mem_req_valid_o) begin
                seen_odd = 1'b1;
                if (!even_filled) begin
                    report_failure("odd request issued before the even fill");
                end
                expect_hex("mem_req_o.addr", mem_req_o.addr, phys_line(28'h521));
            end
        end
        if (!seen_odd) begin
            report_failure("odd request never issued");
        end
        wait_lines(28'h520, 28'h521);
        next_cycle();
        resteer_i = 1'b0;
        finish_test("dual_miss", errs);
    endtask

    task automatic test_reset();
        int errs;
        int n;
        errs = err_count;
        n    = 0;
        next_cycle();
        wb_fip_even_i = 28'h540;
        wb_fip_odd_i  = 28'h541;
        resteer_i     = 1'b1;
        @(negedge clk);
        while (!mem_req_valid_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_failure("no request before the reset");
        end
        next_cycle();
        resteer_i = 1'b0;
        reset_i   = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        expect_hex("fip_even_o", fip_even_o, 28'h0);
        expect_hex("fip_odd_o", fip_odd_o, 28'h0);
        expect_hex("line_even_o flags", {line_even_o.valid, line_even_o.miss,
                   line_even_o.tlb_miss, line_even_o.prot}, 4'b0000);
        expect_hex("line_odd_o flags", {line_odd_o.valid, line_odd_o.miss,
                   line_odd_o.tlb_miss, line_odd_o.prot}, 4'b0000);
        expect_hex("mem_req_valid_o", mem_req_valid_o, 1'b0);
        next_cycle();
        reset_i = 1'b0;
        next_cycle();
        wb_fip_even_i = 28'h304;   // filled in the sequential test
        wb_fip_odd_i  = 28'h305;
        resteer_i     = 1'b1;
        expect_refill(28'h304, 28'h305);
        next_cycle();
        resteer_i = 1'b0;
        finish_test("reset", errs);
    endtask

    //////////////////////////////
    // memory model and watchdog
    //////////////////////////////

    initial begin : memory_model
        fetch_pkg::mem_req_t req;
        int                  delay;
        mem_fill_i      = 1'b0;
        mem_fill_data_i = '0;
        rng_state       = 32'h4287_b69d;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req_valid_o) begin
                req       = mem_req_o;
                rng_state = xorshift32(rng_state);
                delay     = 2 + int'(rng_state % 8);   // 2 to 9 cycles
                repeat (delay - 1) @(posedge clk);
                #1;
                mem_fill_data_i = line_data(req.addr);
                mem_fill_i      = 1'b1;
                @(posedge clk);
                #1;
                mem_fill_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TEST_CYCLES * 20) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset_i         = 1'b1;
        init_addr_i     = '0;
        init_i          = 1'b0;
        bp_fip_even_i   = '0;
        bp_fip_odd_i    = '0;
        branch_i        = 1'b0;
        wb_fip_even_i   = '0;
        wb_fip_odd_i    = '0;
        resteer_i       = 1'b0;
        ld_even_i       = 1'b0;
        ld_odd_i        = 1'b0;
        err_count       = 0;
        test_count      = 0;
        test_fail_count = 0;
        seq_even        = '0;
        seq_odd         = '0;
        setup_tlb();
        repeat (16) @(posedge clk);
        #1;
        reset_i = 1'b0;

        test_init();
        test_priority();
        test_sequential();
        test_tlb();
        test_dual_miss();
        test_reset();

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", test_count,
                 test_fail_count, err_count, u_fetch_top.u_fetch_chk.fail_count);
        if (err_count == 0 && u_fetch_top.u_fetch_chk.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/fetch_chk.sv
`default_nettype none
`timescale 1ns/1ps

// memory port and reset rules of the fetch stage
module fetch_chk (
    input wire                         clk,
    input wire                         reset_i,
    input wire                         fill_i,
    input wire                         req_valid_i,
    input wire fetch_pkg::mem_req_t    req_i,
    input wire fetch_pkg::fetch_line_t line_even_i,
    input wire fetch_pkg::fetch_line_t line_odd_i
);

    int fail_count = 0;

    // a request is held until its fill strobe
    req_held: assert property (@(posedge clk) disable iff (reset_i)
        (req_valid_i && !fill_i) |=> $stable(req_i))
        else begin
            fail_count++;
            $error("memory request changed before its fill");
        end

    reset_quiet: assert property (@(posedge clk)
        reset_i |=> (!line_even_i.valid && !line_odd_i.valid && !req_valid_i))
        else begin
            fail_count++;
            $error("line valid or memory request high during reset");
        end

    hit_or_miss: assert property (@(posedge clk) disable iff (reset_i)
        !(line_even_i.valid && line_even_i.miss) && !(line_odd_i.valid && line_odd_i.miss))
        else begin
            fail_count++;
            $error("line reports valid and miss together");
        end

endmodule

bind fetch_top fetch_chk u_fetch_chk (
    .clk         (clk),
    .reset_i     (reset_i),
    .fill_i      (mem_fill_i),
    .req_valid_i (mem_req_valid_o),
    .req_i       (mem_req_o),
    .line_even_i (line_even_o),
    .line_odd_i  (line_odd_o)
);

`default_nettype wire

//--- verilog/fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_top (
    input  wire                                               clk,
    input  wire                                               reset_i,
    input  wire [31:0]                                        init_addr_i,
    input  wire                                               init_i,
    input  wire [`FETCH_LINE_W-1:0]                           bp_fip_even_i,
    input  wire [`FETCH_LINE_W-1:0]                           bp_fip_odd_i,
    input  wire                                               branch_i,
    input  wire [`FETCH_LINE_W-1:0]                           wb_fip_even_i,
    input  wire [`FETCH_LINE_W-1:0]                           wb_fip_odd_i,
    input  wire                                               resteer_i,
    input  wire                                               ld_even_i,
    input  wire                                               ld_odd_i,
    input  wire fetch_pkg::tlb_entry_t [`FETCH_TLB_ENTRIES-1:0] tlb_entries_i,
    input  wire                                               mem_fill_i,
    input  wire [`FETCH_DATA_W-1:0]                           mem_fill_data_i,
    output logic [`FETCH_LINE_W-1:0]                          fip_even_o,
    output logic [`FETCH_LINE_W-1:0]                          fip_odd_o,
    output fetch_pkg::fetch_line_t                            line_even_o,
    output fetch_pkg::fetch_line_t                            line_odd_o,
    output logic                                              mem_req_valid_o,
    output fetch_pkg::mem_req_t                               mem_req_o
);

    logic [`FETCH_LINE_W-1:0] init_line;
    logic [`FETCH_LINE_W-1:0] init_line_p1;
    logic [`FETCH_LINE_W-1:0] init_fip_even;
    logic [`FETCH_LINE_W-1:0] init_fip_odd;

    fetch_pkg::tlb_result_t    tlb_even;
    fetch_pkg::tlb_result_t    tlb_odd;
    logic                      miss_req_even;
    logic                      miss_req_odd;
    logic [`FETCH_PLINE_W-1:0] miss_pline_even;
    logic [`FETCH_PLINE_W-1:0] miss_pline_odd;
    logic                      fill_even;
    logic                      fill_odd;

    //////////////////////////////
    // init line pair
    //////////////////////////////

    assign init_line    = init_addr_i[31:4] + `FETCH_LINE_W'(1);  // init address plus 16
    assign init_line_p1 = init_line + `FETCH_LINE_W'(1);
    assign init_fip_even = init_addr_i[4] ? init_line_p1 : init_line;
    assign init_fip_odd  = init_addr_i[4] ? init_line : init_line_p1;

    fetch_addr_select u_sel_even (
        .clk        (clk),
        .reset_i    (reset_i),
        .init_fip_i (init_fip_even),
        .bp_fip_i   (bp_fip_even_i),
        .wb_fip_i   (wb_fip_even_i),
        .init_i     (init_i),
        .resteer_i  (resteer_i),
        .branch_i   (branch_i),
        .ld_i       (ld_even_i),
        .fip_o      (fip_even_o)
    );

    fetch_addr_select u_sel_odd (
        .clk        (clk),
        .reset_i    (reset_i),
        .init_fip_i (init_fip_odd),
        .bp_fip_i   (bp_fip_odd_i),
        .wb_fip_i   (wb_fip_odd_i),
        .init_i     (init_i),
        .resteer_i  (resteer_i),
        .branch_i   (branch_i),
        .ld_i       (ld_odd_i),
        .fip_o      (fip_odd_o)
    );

    //////////////////////////////
    // translation and banks
    //////////////////////////////

    itlb u_tlb_even (
        .fip_i     (fip_even_o),
        .entries_i (tlb_entries_i),
        .result_o  (tlb_even)
    );

    itlb u_tlb_odd (
        .fip_i     (fip_odd_o),
        .entries_i (tlb_entries_i),
        .result_o  (tlb_odd)
    );

    icache_bank u_bank_even (
        .clk          (clk),
        .reset_i      (reset_i),
        .tlb_i        (tlb_even),
        .fill_i       (fill_even),
        .fill_data_i  (mem_fill_data_i),
        .line_o       (line_even_o),
        .miss_req_o   (miss_req_even),
        .miss_pline_o (miss_pline_even)
    );

    icache_bank u_bank_odd (
        .clk          (clk),
        .reset_i      (reset_i),
        .tlb_i        (tlb_odd),
        .fill_i       (fill_odd),
        .fill_data_i  (mem_fill_data_i),
        .line_o       (line_odd_o),
        .miss_req_o   (miss_req_odd),
        .miss_pline_o (miss_pline_odd)
    );

    fill_ctrl u_fill_ctrl (
        .clk               (clk),
        .reset_i           (reset_i),
        .miss_req_even_i   (miss_req_even),
        .miss_pline_even_i (miss_pline_even),
        .miss_req_odd_i    (miss_req_odd),
        .miss_pline_odd_i  (miss_pline_odd),
        .mem_fill_i        (mem_fill_i),
        .fill_even_o       (fill_even),
        .fill_odd_o        (fill_odd),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_o         (mem_req_o)
    );

endmodule

`default_nettype wire

//--- verilog/fill_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

// one fill at a time, even bank served first
module fill_ctrl (
    input  wire                       clk,
    input  wire                       reset_i,
    input  wire                       miss_req_even_i,
    input  wire [`FETCH_PLINE_W-1:0]  miss_pline_even_i,
    input  wire                       miss_req_odd_i,
    input  wire [`FETCH_PLINE_W-1:0]  miss_pline_odd_i,
    input  wire                       mem_fill_i,
    output logic                      fill_even_o,
    output logic                      fill_odd_o,
    output logic                      mem_req_valid_o,
    output fetch_pkg::mem_req_t       mem_req_o
);

    fetch_pkg::mem_req_t req_q;
    logic                busy_q;
    logic                even_pend;
    logic                odd_pend;
    logic                grant_free;

    // the bank being filled still holds its request in the fill cycle
    assign even_pend  = miss_req_even_i && !(busy_q && !req_q.bank);
    assign odd_pend   = miss_req_odd_i && !(busy_q && req_q.bank);
    assign grant_free = !busy_q || mem_fill_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            req_q  <= '0;
        end else if (grant_free) begin
            if (even_pend) begin
                busy_q <= 1'b1;
                req_q  <= '{addr: miss_pline_even_i, bank: 1'b0};
            end else if (odd_pend) begin
                busy_q <= 1'b1;
                req_q  <= '{addr: miss_pline_odd_i, bank: 1'b1};
            end else begin
                busy_q <= 1'b0;
            end
        end
    end

    assign mem_req_valid_o = busy_q;
    assign mem_req_o       = req_q;

    assign fill_even_o = busy_q && mem_fill_i && !req_q.bank;
    assign fill_odd_o  = busy_q && mem_fill_i && req_q.bank;

endmodule

`default_nettype wire

//--- verilog/icache_bank.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

// one direct mapped bank, lookup result one cycle after the address
module icache_bank (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire fetch_pkg::tlb_result_t tlb_i,
    input  wire                        fill_i,
    input  wire [`FETCH_DATA_W-1:0]    fill_data_i,
    output fetch_pkg::fetch_line_t     line_o,
    output logic                       miss_req_o,
    output logic [`FETCH_PLINE_W-1:0]  miss_pline_o
);

    logic [`FETCH_TAG_W-1:0]  tag_mem  [`FETCH_SETS];
    logic [`FETCH_DATA_W-1:0] data_mem [`FETCH_SETS];
    logic [`FETCH_SETS-1:0]   valid_q;

    fetch_pkg::bank_state_e    state_q;
    logic [`FETCH_PLINE_W-1:0] miss_pline_q;

    logic [`FETCH_SET_W-1:0] rd_set;
    logic [`FETCH_SET_W-1:0] fill_set;
    logic [`FETCH_TAG_W-1:0] rd_tag;
    logic                    tag_hit;
    logic                    clean;     // translation ok
    logic                    lookup;
    logic                    fill_wr;

    logic                     hit_q;
    logic                     miss_q;
    logic                     tlb_miss_q;
    logic                     prot_q;
    logic [`FETCH_DATA_W-1:0] data_q;

    // bit 0 picks the bank and is not stored
    assign rd_set   = tlb_i.pline[`FETCH_SET_W:1];
    assign rd_tag   = tlb_i.pline[`FETCH_PLINE_W-1:`FETCH_SET_W+1];
    assign fill_set = miss_pline_q[`FETCH_SET_W:1];

    assign tag_hit = valid_q[rd_set] && (tag_mem[rd_set] == rd_tag);
    assign clean   = tlb_i.hit && !tlb_i.prot;
    assign lookup  = (state_q == fetch_pkg::BANK_LOOKUP);
    assign fill_wr = (state_q == fetch_pkg::BANK_WAIT_FILL) && fill_i;

    //////////////////////////////
    // state and result flags
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= fetch_pkg::BANK_LOOKUP;
            valid_q    <= '0;
            hit_q      <= 1'b0;
            miss_q     <= 1'b0;
            tlb_miss_q <= 1'b0;
            prot_q     <= 1'b0;
        end else if (lookup) begin
            hit_q      <= clean && tag_hit;
            miss_q     <= clean && !tag_hit;
            tlb_miss_q <= tlb_i.miss;
            prot_q     <= tlb_i.prot;
            if (clean && !tag_hit) begin
                state_q <= fetch_pkg::BANK_WAIT_FILL;
            end
        end else if (fill_wr) begin
            valid_q[fill_set] <= 1'b1;
            state_q           <= fetch_pkg::BANK_LOOKUP;  // miss flag stays until next lookup
        end
    end

    //////////////////////////////
    // arrays and line data
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (lookup) begin
            data_q       <= data_mem[rd_set];
            miss_pline_q <= tlb_i.pline;   // frozen while waiting for the fill
        end
        if (fill_wr) begin
            data_mem[fill_set] <= fill_data_i;
            tag_mem[fill_set]  <= miss_pline_q[`FETCH_PLINE_W-1:`FETCH_SET_W+1];
        end
    end

    assign line_o = '{
        data:     data_q,
        valid:    hit_q,
        miss:     miss_q,
        tlb_miss: tlb_miss_q,
        prot:     prot_q
    };

    assign miss_req_o   = (state_q == fetch_pkg::BANK_WAIT_FILL);
    assign miss_pline_o = miss_pline_q;

endmodule

`default_nettype wire

//--- verilog/itlb.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

// fully associative lookup, no state
module itlb (
    input  wire [`FETCH_LINE_W-1:0]                           fip_i,
    input  wire fetch_pkg::tlb_entry_t [`FETCH_TLB_ENTRIES-1:0] entries_i,
    output fetch_pkg::tlb_result_t                            result_o
);

    localparam int OFF_W   = `FETCH_LINE_W - `FETCH_VPN_W;  // line bits inside a page
    localparam int FRAME_W = `FETCH_PLINE_W - OFF_W;

    logic [`FETCH_VPN_W-1:0]       vpn;
    logic [`FETCH_TLB_ENTRIES-1:0] match;
    fetch_pkg::tlb_entry_t         hit_entry;
    logic                          hit;

    assign vpn = fip_i[`FETCH_LINE_W-1:OFF_W];

    // tag compare on every entry at once
    always_comb begin
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            match[i] = entries_i[i].valid && entries_i[i].present &&
                       (entries_i[i].vpn == vpn);
        end
    end

    // at most one entry matches, so an OR acts as the select
    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit_entry = hit_entry | entries_i[i];
            end
        end
    end

    assign hit = |match;

    assign result_o = '{
        pline: {hit_entry.pfn[FRAME_W-1:0], fip_i[OFF_W-1:0]},
        hit:   hit,
        miss:  !hit,
        prot:  hit && hit_entry.pcd   // no fetch from MMIO pages
    };

endmodule

`default_nettype wire

//--- verilog/fetch_addr_select.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

// fetch address for one bank: control flow target or the sequential register
module fetch_addr_select (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire [`FETCH_LINE_W-1:0]  init_fip_i,
    input  wire [`FETCH_LINE_W-1:0]  bp_fip_i,
    input  wire [`FETCH_LINE_W-1:0]  wb_fip_i,
    input  wire                      init_i,
    input  wire                      resteer_i,
    input  wire                      branch_i,
    input  wire                      ld_i,
    output logic [`FETCH_LINE_W-1:0] fip_o
);

    fetch_pkg::cf_sel_e       cf_sel;
    logic [`FETCH_LINE_W-1:0] fip_q;

    //////////////////////////////
    // control flow priority
    //////////////////////////////

    always_comb begin
        if (init_i) begin
            cf_sel = fetch_pkg::CF_INIT;
        end else if (resteer_i) begin
            cf_sel = fetch_pkg::CF_RESTEER;
        end else if (branch_i) begin
            cf_sel = fetch_pkg::CF_BRANCH;
        end else begin
            cf_sel = fetch_pkg::CF_SEQ;
        end
    end

    always_comb begin
        case (cf_sel)
            fetch_pkg::CF_INIT:    fip_o = init_fip_i;
            fetch_pkg::CF_RESTEER: fip_o = wb_fip_i;
            fetch_pkg::CF_BRANCH:  fip_o = bp_fip_i;
            default:               fip_o = fip_q;   // no control flow
        endcase
    end

    //////////////////////////////
    // sequential address register
    //////////////////////////////

    // both banks interleave, so each one steps two lines
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fip_q <= '0;
        end else if (ld_i) begin
            fip_q <= fip_o + `FETCH_LINE_W'(2);
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    // control flow source, highest value wins
    typedef enum logic [1:0] {
        CF_SEQ     = 2'd0,
        CF_BRANCH  = 2'd1,
        CF_RESTEER = 2'd2,
        CF_INIT    = 2'd3
    } cf_sel_e;

    typedef struct packed {
        logic [`FETCH_VPN_W-1:0] vpn;
        logic [`FETCH_PFN_W-1:0] pfn;
        logic                    valid;
        logic                    present;
        logic                    rw;
        logic                    pcd;    // page is MMIO
    } tlb_entry_t;

    typedef struct packed {
        logic [`FETCH_PLINE_W-1:0] pline;
        logic                      hit;
        logic                      miss;
        logic                      prot;
    } tlb_result_t;

    typedef struct packed {
        logic [`FETCH_DATA_W-1:0] data;
        logic                     valid;
        logic                     miss;
        logic                     tlb_miss;
        logic                     prot;
    } fetch_line_t;

    typedef struct packed {
        logic [`FETCH_PLINE_W-1:0] addr;
        logic                      bank;   // 0 is the even bank
    } mem_req_t;

    typedef enum logic {
        BANK_LOOKUP    = 1'b0,
        BANK_WAIT_FILL = 1'b1
    } bank_state_e;

endpackage

`default_nettype wire

//--- include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// virtual fetch line address, byte address bits 31:4
`define FETCH_LINE_W 28

// one cache line of instruction bytes
`define FETCH_DATA_W 128

// instruction TLB
`define FETCH_TLB_ENTRIES 8
`define FETCH_VPN_W 20  // line address bits 27:8
`define FETCH_PFN_W 20

// physical line is 3 frame bits over 8 page offset line bits
`define FETCH_PLINE_W 11

// per bank geometry
`define FETCH_SETS 16
`define FETCH_SET_W 4   // physical line bits 4:1
`define FETCH_TAG_W 6   // physical line bits 10:5

`endif
